//--- hw/exec_pkg.sv
`default_nettype none

package exec_pkg;

	localparam int XLEN      = 32;
	localparam int REG_AW    = 5;
	// one quotient bit per cycle
	localparam int DIV_STEPS = 32;

	typedef logic [XLEN-1:0]   word_t;
	// hi in the upper half, lo in the lower half
	typedef logic [2*XLEN-1:0] dword_t;
	typedef logic [REG_AW-1:0] reg_addr_t;

	typedef enum logic [4:0] {
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_NOR,
		OP_SLT,
		OP_SLTU,
		OP_SLL,
		OP_SRL,
		OP_SRA,
		OP_MULT,
		OP_MULTU,
		OP_DIV,
		OP_DIVU,
		OP_MFHI,
		OP_MFLO
	} op_e;

	typedef enum logic [1:0] {
		RES_GPR,
		RES_HILO,
		RES_HI,
		RES_LO
	} res_kind_e;

	typedef struct packed {
		res_kind_e kind;
		reg_addr_t dst;
		dword_t    value;
		logic      is_div;
	} path_res_t;

endpackage

`default_nettype wire

//--- hw/exec_if.sv
`default_nettype none

// decoded operation from the issue stage to one execution path
interface exec_op_if;
	logic                valid;
	logic                ready;
	exec_pkg::op_e       op;
	exec_pkg::word_t     src_a;
	exec_pkg::word_t     src_b;
	exec_pkg::reg_addr_t dst;

	modport issuer (
		output valid,
		output op,
		output src_a,
		output src_b,
		output dst,
		input  ready
	);

	modport executor (
		input  valid,
		input  op,
		input  src_a,
		input  src_b,
		input  dst,
		output ready
	);
endinterface

// path result towards the writeback
interface exec_res_if;
	logic                valid;
	logic                ready;
	exec_pkg::path_res_t res;

	modport producer (
		output valid,
		output res,
		input  ready
	);

	modport consumer (
		input  valid,
		input  res,
		output ready
	);
endinterface

`default_nettype wire

//--- hw/exec_issue.sv
`default_nettype none

module exec_issue (
	input  wire                      clk,
	input  wire                      rst_i,
	input  wire                      op_valid_i,
	output logic                     op_ready_o,
	input  wire exec_pkg::op_e       op_code_i,
	input  wire exec_pkg::word_t     op_a_i,
	input  wire exec_pkg::word_t     op_b_i,
	input  wire exec_pkg::reg_addr_t op_dst_i,
	input  wire                      alu_retire_i,
	input  wire                      div_retire_i,
	exec_op_if.issuer                alu_o,
	exec_op_if.issuer                div_o
);
	logic [1:0] alu_cnt_q;
	logic       div_busy_q;
	logic       is_div;
	logic       alu_open;
	logic       div_open;
	logic       alu_fire;
	logic       div_fire;

	assign is_div = (op_code_i == exec_pkg::OP_DIV) || (op_code_i == exec_pkg::OP_DIVU);

	// nothing issues behind a divide
	assign alu_open = !div_busy_q;
	// divide waits until the alu path has drained
	assign div_open = !div_busy_q && (alu_cnt_q == 2'd0);

	assign alu_o.valid = op_valid_i && !is_div && alu_open;
	assign alu_o.op    = op_code_i;
	assign alu_o.src_a = op_a_i;
	assign alu_o.src_b = op_b_i;
	assign alu_o.dst   = op_dst_i;

	assign div_o.valid = op_valid_i && is_div && div_open;
	assign div_o.op    = op_code_i;
	assign div_o.src_a = op_a_i;
	assign div_o.src_b = op_b_i;
	assign div_o.dst   = op_dst_i;

	assign op_ready_o = is_div ? (div_open && div_o.ready) : (alu_open && alu_o.ready);

	assign alu_fire = alu_o.valid && alu_o.ready;
	assign div_fire = div_o.valid && div_o.ready;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			alu_cnt_q  <= 2'd0;
			div_busy_q <= 1'b0;
		end else begin
			// dispatch and retire in one cycle cancel out
			if (alu_fire && !alu_retire_i)
				alu_cnt_q <= alu_cnt_q + 2'd1;
			else if (!alu_fire && alu_retire_i)
				alu_cnt_q <= alu_cnt_q - 2'd1;
			if (div_fire)
				div_busy_q <= 1'b1;
			else if (div_retire_i)
				div_busy_q <= 1'b0;
		end
	end
endmodule

`default_nettype wire

//--- hw/alu_path.sv
`default_nettype none

module alu_path (
	input  wire          clk,
	input  wire          rst_i,
	exec_op_if.executor  op_i,
	exec_res_if.producer res_o
);
	logic                               s1_valid_q;
	exec_pkg::op_e                      s1_op_q;
	exec_pkg::word_t                    s1_a_q;
	exec_pkg::word_t                    s1_b_q;
	exec_pkg::reg_addr_t                s1_dst_q;
	exec_pkg::res_kind_e                s1_kind_q;
	exec_pkg::res_kind_e                kind_dec;
	logic                               s2_valid_q;
	exec_pkg::path_res_t                s2_res_q;
	logic                               s1_en;
	logic                               s2_en;
	exec_pkg::word_t                    word_val;
	exec_pkg::dword_t                   value;
	logic signed [2*exec_pkg::XLEN-1:0] prod_s;
	exec_pkg::dword_t                   prod_u;

	always_comb begin
		case (op_i.op)
			exec_pkg::OP_MULT,
			exec_pkg::OP_MULTU: kind_dec = exec_pkg::RES_HILO;
			exec_pkg::OP_MFHI:  kind_dec = exec_pkg::RES_HI;
			exec_pkg::OP_MFLO:  kind_dec = exec_pkg::RES_LO;
			default:            kind_dec = exec_pkg::RES_GPR;
		endcase
	end

	// output stall backs up into stage one
	assign s2_en      = !s2_valid_q || res_o.ready;
	assign s1_en      = !s1_valid_q || s2_en;
	assign op_i.ready = s1_en;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			s1_valid_q <= 1'b0;
			s2_valid_q <= 1'b0;
		end else begin
			if (s1_en)
				s1_valid_q <= op_i.valid;
			if (s2_en)
				s2_valid_q <= s1_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_en && op_i.valid) begin
			s1_op_q   <= op_i.op;
			s1_a_q    <= op_i.src_a;
			s1_b_q    <= op_i.src_b;
			s1_dst_q  <= op_i.dst;
			s1_kind_q <= kind_dec;
		end
	end

	// full 64 bit products
	assign prod_s = $signed(s1_a_q) * $signed(s1_b_q);
	assign prod_u = s1_a_q * s1_b_q;

	always_comb begin
		case (s1_op_q)
			exec_pkg::OP_ADD:  word_val = s1_a_q + s1_b_q;
			exec_pkg::OP_SUB:  word_val = s1_a_q - s1_b_q;
			exec_pkg::OP_AND:  word_val = s1_a_q & s1_b_q;
			exec_pkg::OP_OR:   word_val = s1_a_q | s1_b_q;
			exec_pkg::OP_XOR:  word_val = s1_a_q ^ s1_b_q;
			exec_pkg::OP_NOR:  word_val = ~(s1_a_q | s1_b_q);
			exec_pkg::OP_SLT:  word_val = exec_pkg::word_t'($signed(s1_a_q) < $signed(s1_b_q));
			exec_pkg::OP_SLTU: word_val = exec_pkg::word_t'(s1_a_q < s1_b_q);
			exec_pkg::OP_SLL:  word_val = s1_a_q << s1_b_q[4:0];
			exec_pkg::OP_SRL:  word_val = s1_a_q >> s1_b_q[4:0];
			exec_pkg::OP_SRA:  word_val = exec_pkg::word_t'($signed(s1_a_q) >>> s1_b_q[4:0]);
			default:           word_val = '0;
		endcase
		case (s1_op_q)
			exec_pkg::OP_MULT:  value = exec_pkg::dword_t'(prod_s);
			exec_pkg::OP_MULTU: value = prod_u;
			default:            value = {{exec_pkg::XLEN{1'b0}}, word_val};
		endcase
	end

	always_ff @(posedge clk) begin
		if (s2_en && s1_valid_q) begin
			s2_res_q.kind   <= s1_kind_q;
			s2_res_q.dst    <= s1_dst_q;
			s2_res_q.value  <= value;
			s2_res_q.is_div <= 1'b0;
		end
	end

	assign res_o.valid = s2_valid_q;
	assign res_o.res   = s2_res_q;
endmodule

`default_nettype wire

//--- hw/div_path.sv
`default_nettype none

module div_path (
	input  wire          clk,
	input  wire          rst_i,
	exec_op_if.executor  op_i,
	exec_res_if.producer res_o
);
	typedef enum logic [1:0] {
		DIV_IDLE,
		DIV_RUN,
		DIV_DONE
	} div_state_e;

	div_state_e                             state_q;
	logic [$clog2(exec_pkg::DIV_STEPS)-1:0] step_q;
	exec_pkg::word_t                        rem_q;
	exec_pkg::word_t                        quo_q;
	exec_pkg::word_t                        dvs_q;
	logic                                   neg_quo_q;
	logic                                   neg_rem_q;
	exec_pkg::reg_addr_t                    dst_q;
	logic                                   op_signed;
	logic                                   a_neg;
	logic                                   b_neg;
	exec_pkg::word_t                        mag_a;
	exec_pkg::word_t                        mag_b;
	logic [exec_pkg::XLEN:0]                rem_shift;
	logic [exec_pkg::XLEN:0]                diff;
	exec_pkg::word_t                        quo_fix;
	exec_pkg::word_t                        rem_fix;

	assign op_signed = (op_i.op == exec_pkg::OP_DIV);
	assign a_neg     = op_signed && op_i.src_a[exec_pkg::XLEN-1];
	assign b_neg     = op_signed && op_i.src_b[exec_pkg::XLEN-1];
	assign mag_a     = a_neg ? -op_i.src_a : op_i.src_a;
	assign mag_b     = b_neg ? -op_i.src_b : op_i.src_b;

	// busy from acceptance until the result has left
	assign op_i.ready = (state_q == DIV_IDLE);

	// restoring step shifts the next dividend bit out of the top of quo_q
	assign rem_shift = {rem_q, quo_q[exec_pkg::XLEN-1]};
	assign diff      = rem_shift - {1'b0, dvs_q};

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= DIV_IDLE;
		end else begin
			case (state_q)
				DIV_IDLE: begin
					if (op_i.valid)
						state_q <= DIV_RUN;
				end
				DIV_RUN: begin
					if (step_q == '0)
						state_q <= DIV_DONE;
				end
				default: begin
					if (res_o.ready)
						state_q <= DIV_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (op_i.valid && op_i.ready) begin
			step_q    <= $bits(step_q)'(exec_pkg::DIV_STEPS - 1);
			rem_q     <= '0;
			quo_q     <= mag_a;
			dvs_q     <= mag_b;
			neg_quo_q <= a_neg ^ b_neg;
			neg_rem_q <= a_neg;
			dst_q     <= op_i.dst;
		end else if (state_q == DIV_RUN) begin
			step_q <= step_q - 1'b1;
			rem_q  <= diff[exec_pkg::XLEN] ? rem_shift[exec_pkg::XLEN-1:0]
			                               : diff[exec_pkg::XLEN-1:0];
			quo_q  <= {quo_q[exec_pkg::XLEN-2:0], !diff[exec_pkg::XLEN]};
		end
	end

	// remainder follows the dividend sign
	assign quo_fix = neg_quo_q ? -quo_q : quo_q;
	assign rem_fix = neg_rem_q ? -rem_q : rem_q;

	assign res_o.valid = (state_q == DIV_DONE);
	assign res_o.res   = '{
		kind:   exec_pkg::RES_HILO,
		dst:    dst_q,
		value:  {rem_fix, quo_fix},
		is_div: 1'b1
	};
endmodule

`default_nettype wire

//--- hw/hilo_writeback.sv
`default_nettype none

module hilo_writeback (
	input  wire                  clk,
	input  wire                  rst_i,
	exec_res_if.consumer         alu_i,
	exec_res_if.consumer         div_i,
	output logic                 res_valid_o,
	input  wire                  res_ready_i,
	output exec_pkg::reg_addr_t  res_dst_o,
	output exec_pkg::word_t      res_data_o,
	output logic                 alu_retire_o,
	output logic                 div_retire_o
);
	logic                out_free;
	logic                take;
	logic                to_hilo;
	exec_pkg::path_res_t sel;
	exec_pkg::word_t     hi_q;
	exec_pkg::word_t     lo_q;

	// output register empty or draining this cycle
	assign out_free = !res_valid_o || res_ready_i;

	// divider wins if both ever show up
	assign div_i.ready = out_free;
	assign alu_i.ready = out_free && !div_i.valid;

	assign sel     = div_i.valid ? div_i.res : alu_i.res;
	assign take    = (div_i.valid || alu_i.valid) && out_free;
	assign to_hilo = (sel.kind == exec_pkg::RES_HILO);

	assign alu_retire_o = take && !sel.is_div;
	assign div_retire_o = take && sel.is_div;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			res_valid_o <= 1'b0;
			hi_q        <= '0;
			lo_q        <= '0;
		end else begin
			if (take && !to_hilo)
				res_valid_o <= 1'b1;
			else if (res_ready_i)
				res_valid_o <= 1'b0;
			if (take && to_hilo) begin
				hi_q <= sel.value[exec_pkg::XLEN +: exec_pkg::XLEN];
				lo_q <= sel.value[0 +: exec_pkg::XLEN];
			end
		end
	end

	// mfhi and mflo read the register pair here
	always_ff @(posedge clk) begin
		if (take) begin
			res_dst_o <= sel.dst;
			case (sel.kind)
				exec_pkg::RES_HI: res_data_o <= hi_q;
				exec_pkg::RES_LO: res_data_o <= lo_q;
				default:          res_data_o <= sel.value[0 +: exec_pkg::XLEN];
			endcase
		end
	end
endmodule

`default_nettype wire

//--- hw/exec_unit.sv
`default_nettype none

module exec_unit (
	input  wire                      clk,
	input  wire                      rst_i,
	input  wire                      op_valid_i,
	output logic                     op_ready_o,
	input  wire exec_pkg::op_e       op_code_i,
	input  wire exec_pkg::word_t     op_a_i,
	input  wire exec_pkg::word_t     op_b_i,
	input  wire exec_pkg::reg_addr_t op_dst_i,
	output logic                     res_valid_o,
	input  wire                      res_ready_i,
	output exec_pkg::reg_addr_t      res_dst_o,
	output exec_pkg::word_t          res_data_o
);
	logic alu_retire;
	logic div_retire;

	exec_op_if  alu_op_bus ();
	exec_op_if  div_op_bus ();
	exec_res_if alu_res_bus ();
	exec_res_if div_res_bus ();

	exec_issue m_issue (
		.clk          (clk),
		.rst_i        (rst_i),
		.op_valid_i   (op_valid_i),
		.op_ready_o   (op_ready_o),
		.op_code_i    (op_code_i),
		.op_a_i       (op_a_i),
		.op_b_i       (op_b_i),
		.op_dst_i     (op_dst_i),
		.alu_retire_i (alu_retire),
		.div_retire_i (div_retire),
		.alu_o        (alu_op_bus),
		.div_o        (div_op_bus)
	);

	alu_path m_alu_path (
		.clk   (clk),
		.rst_i (rst_i),
		.op_i  (alu_op_bus),
		.res_o (alu_res_bus)
	);

	div_path m_div_path (
		.clk   (clk),
		.rst_i (rst_i),
		.op_i  (div_op_bus),
		.res_o (div_res_bus)
	);

	hilo_writeback m_writeback (
		.clk          (clk),
		.rst_i        (rst_i),
		.alu_i        (alu_res_bus),
		.div_i        (div_res_bus),
		.res_valid_o  (res_valid_o),
		.res_ready_i  (res_ready_i),
		.res_dst_o    (res_dst_o),
		.res_data_o   (res_data_o),
		.alu_retire_o (alu_retire),
		.div_retire_o (div_retire)
	);
endmodule

`default_nettype wire

//--- dv/exec_unit_tb_tasks.svh
// expected integer results straight from the instruction rules
function automatic exec_pkg::word_t alu_ref(input exec_pkg::op_e op,
		input exec_pkg::word_t a, input exec_pkg::word_t b);
	case (op)
		exec_pkg::OP_ADD:  return a + b;
		exec_pkg::OP_SUB:  return a - b;
		exec_pkg::OP_AND:  return a & b;
		exec_pkg::OP_OR:   return a | b;
		exec_pkg::OP_XOR:  return a ^ b;
		exec_pkg::OP_NOR:  return ~(a | b);
		exec_pkg::OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		exec_pkg::OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
		exec_pkg::OP_SLL:  return a << b[4:0];
		exec_pkg::OP_SRL:  return a >> b[4:0];
		exec_pkg::OP_SRA:  return $signed(a) >>> b[4:0];
		default:           return '0;
	endcase
endfunction

// queues one op and its expected result while tracking hi/lo
task automatic queue_op(input exec_pkg::op_e op, input exec_pkg::word_t a,
		input exec_pkg::word_t b, input exec_pkg::reg_addr_t dst);
	op_q.push_back(op_rec_t'{op, a, b, dst});
	case (op)
		exec_pkg::OP_MULT:  {hi_m, lo_m} = longint'($signed(a)) * longint'($signed(b));
		exec_pkg::OP_MULTU: {hi_m, lo_m} = {32'd0, a} * {32'd0, b};
		exec_pkg::OP_DIV: begin
			lo_m = $signed(a) / $signed(b);
			hi_m = $signed(a) % $signed(b);
		end
		exec_pkg::OP_DIVU: begin
			lo_m = a / b;
			hi_m = a % b;
		end
		exec_pkg::OP_MFHI: exp_q.push_back(res_rec_t'{dst, hi_m});
		exec_pkg::OP_MFLO: exp_q.push_back(res_rec_t'{dst, lo_m});
		default:           exp_q.push_back(res_rec_t'{dst, alu_ref(op, a, b)});
	endcase
endtask

task automatic send_op(input op_rec_t rec);
	int   waited;
	logic done;
	waited = 0;
	done   = 1'b0;
	while (!done && !timed_out) begin
		@(negedge clk);
		op_valid_i = 1'b1;
		op_code_i  = rec.op;
		op_a_i     = rec.a;
		op_b_i     = rec.b;
		op_dst_i   = rec.dst;
		#1;
		if (op_ready_o) begin
			done = 1'b1;
			@(posedge clk);
		end else begin
			saw_stall = 1'b1;
			if (waited == WAIT_LIMIT) begin
				$display("timeout: op_ready_o stayed low, op not accepted");
				timeout_errs++;
				timed_out = 1'b1;
			end
		end
		waited++;
	end
endtask

// holds res_ready_i low for hold cycles and then waits for a result
task automatic get_res(input int hold, output exec_pkg::reg_addr_t dst,
		output exec_pkg::word_t data);
	int   waited;
	logic got;
	waited = 0;
	got    = 1'b0;
	dst    = '0;
	data   = '0;
	repeat (hold) begin
		@(negedge clk);
		res_ready_i = 1'b0;
	end
	while (!got && !timed_out) begin
		@(negedge clk);
		res_ready_i = 1'b1;
		#1;
		if (res_valid_o) begin
			dst  = res_dst_o;
			data = res_data_o;
			got  = 1'b1;
			@(posedge clk);
		end else if (waited == WAIT_LIMIT) begin
			$display("timeout: no result arrived on res_valid_o");
			timeout_errs++;
			timed_out = 1'b1;
		end
		waited++;
	end
endtask

task automatic compare_bit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("Mismatch %s: got %h expected %h", name, got, exp);
		mismatch_errs++;
	end
endtask

task automatic compare_dst(input string name, input exec_pkg::reg_addr_t got,
		input exec_pkg::reg_addr_t exp);
	if (got !== exp) begin
		$display("Mismatch %s: got %h expected %h", name, got, exp);
		mismatch_errs++;
	end
endtask

task automatic compare_word(input string name, input exec_pkg::word_t got,
		input exec_pkg::word_t exp);
	if (got !== exp) begin
		$display("Mismatch %s: got %h expected %h", name, got, exp);
		mismatch_errs++;
	end
endtask

// sends the queued ops while collecting results in parallel
task automatic run_burst(input int hold_max);
	res_rec_t            exp;
	exec_pkg::reg_addr_t dst;
	exec_pkg::word_t     data;
	fork
		begin
			while (op_q.size() != 0)
				send_op(op_q.pop_front());
			@(negedge clk);
			op_valid_i = 1'b0;
		end
		begin
			while (exp_q.size() != 0) begin
				exp = exp_q.pop_front();
				get_res((hold_max == 0) ? 0 : $urandom_range(hold_max, 2), dst, data);
				if (!timed_out) begin
					compare_dst("res_dst_o", dst, exp.dst);
					compare_word("res_data_o", data, exp.data);
				end
			end
		end
	join
	@(negedge clk);
	res_ready_i = 1'b0;
	#1;
	if (res_valid_o && !timed_out) begin
		$display("unexpected extra result on res_valid_o after the burst");
		other_errs++;
	end
endtask

task automatic check_reset_state();
	#1;
	compare_bit("res_valid_o", res_valid_o, 1'b0);
	compare_bit("op_ready_o", op_ready_o, 1'b1);
	queue_op(exec_pkg::OP_MFHI, '0, '0, 5'd1);
	queue_op(exec_pkg::OP_MFLO, '0, '0, 5'd2);
	run_burst(0);
endtask

task automatic int_op_results();
	int k;
	repeat (2) begin
		for (k = int'(exec_pkg::OP_ADD); k <= int'(exec_pkg::OP_SRA); k++)
			queue_op(exec_pkg::op_e'(k), $urandom(), $urandom(), exec_pkg::reg_addr_t'(k + 1));
	end
	run_burst(0);
endtask

task automatic mult_and_moves();
	exec_pkg::word_t a;
	exec_pkg::word_t b;
	repeat (3) begin
		a = $urandom();
		b = $urandom();
		queue_op(exec_pkg::OP_MULT, a, b, 5'd3);
		queue_op(exec_pkg::OP_MFHI, '0, '0, 5'd4);
		queue_op(exec_pkg::OP_MFLO, '0, '0, 5'd5);
		queue_op(exec_pkg::OP_MULTU, a, b, 5'd6);
		queue_op(exec_pkg::OP_MFHI, '0, '0, 5'd7);
		queue_op(exec_pkg::OP_MFLO, '0, '0, 5'd8);
	end
	run_burst(0);
endtask

task automatic divide_and_moves();
	exec_pkg::word_t a;
	exec_pkg::word_t b;
	repeat (6) begin
		a = $urandom();
		// small divisors of either sign give useful quotients
		b = $urandom() >> $urandom_range(31, 0);
		if ($urandom_range(1, 0) == 1)
			b = -b;
		if (b == 0)
			b = 32'd1;
		queue_op(exec_pkg::OP_DIV, a, b, 5'd9);
		queue_op(exec_pkg::OP_MFLO, '0, '0, 5'd10);
		queue_op(exec_pkg::OP_MFHI, '0, '0, 5'd11);
		queue_op(exec_pkg::OP_DIVU, a, b, 5'd12);
		queue_op(exec_pkg::OP_MFLO, '0, '0, 5'd13);
		queue_op(exec_pkg::OP_MFHI, '0, '0, 5'd14);
	end
	run_burst(0);
endtask

task automatic mixed_order();
	queue_op(exec_pkg::OP_ADD, $urandom(), $urandom(), 5'd20);
	queue_op(exec_pkg::OP_SUB, $urandom(), $urandom(), 5'd21);
	queue_op(exec_pkg::OP_XOR, $urandom(), $urandom(), 5'd22);
	queue_op(exec_pkg::OP_DIV, $urandom(), 32'd7, 5'd23);
	queue_op(exec_pkg::OP_MFLO, '0, '0, 5'd24);
	queue_op(exec_pkg::OP_SLT, $urandom(), $urandom(), 5'd25);
	queue_op(exec_pkg::OP_MFHI, '0, '0, 5'd26);
	run_burst(0);
endtask

task automatic hold_results();
	saw_stall = 1'b0;
	repeat (12)
		queue_op(exec_pkg::op_e'($urandom_range(10, 0)), $urandom(), $urandom(),
			exec_pkg::reg_addr_t'($urandom()));
	run_burst(6);
	if (!saw_stall) begin
		$display("op_ready_o never dropped while results were held back");
		other_errs++;
	end
endtask

//--- dv/exec_unit_tb.sv
`default_nettype none

module exec_unit_tb;
	localparam int CLK_PERIOD = 40;
	localparam int WAIT_LIMIT = 200;

	typedef struct packed {
		exec_pkg::op_e       op;
		exec_pkg::word_t     a;
		exec_pkg::word_t     b;
		exec_pkg::reg_addr_t dst;
	} op_rec_t;

	typedef struct packed {
		exec_pkg::reg_addr_t dst;
		exec_pkg::word_t     data;
	} res_rec_t;

	logic                clk;
	logic                rst_i;
	logic                op_valid_i;
	logic                op_ready_o;
	exec_pkg::op_e       op_code_i;
	exec_pkg::word_t     op_a_i;
	exec_pkg::word_t     op_b_i;
	exec_pkg::reg_addr_t op_dst_i;
	logic                res_valid_o;
	logic                res_ready_i;
	exec_pkg::reg_addr_t res_dst_o;
	exec_pkg::word_t     res_data_o;

	op_rec_t         op_q[$];
	res_rec_t        exp_q[$];
	// hi/lo as left by the ops queued so far
	exec_pkg::word_t hi_m;
	exec_pkg::word_t lo_m;
	int              mismatch_errs;
	int              timeout_errs;
	int              other_errs;
	logic            timed_out;
	logic            saw_stall;

	exec_unit dut (
		.clk         (clk),
		.rst_i       (rst_i),
		.op_valid_i  (op_valid_i),
		.op_ready_o  (op_ready_o),
		.op_code_i   (op_code_i),
		.op_a_i      (op_a_i),
		.op_b_i      (op_b_i),
		.op_dst_i    (op_dst_i),
		.res_valid_o (res_valid_o),
		.res_ready_i (res_ready_i),
		.res_dst_o   (res_dst_o),
		.res_data_o  (res_data_o)
	);

	`include "exec_unit_tb_tasks.svh"

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		void'($urandom(32'h4918_ceae));
		rst_i         = 1'b1;
		op_valid_i    = 1'b0;
		op_code_i     = exec_pkg::OP_ADD;
		op_a_i        = '0;
		op_b_i        = '0;
		op_dst_i      = '0;
		res_ready_i   = 1'b0;
		hi_m          = '0;
		lo_m          = '0;
		mismatch_errs = 0;
		timeout_errs  = 0;
		other_errs    = 0;
		timed_out     = 1'b0;
		saw_stall     = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		check_reset_state();
		int_op_results();
		mult_and_moves();
		divide_and_moves();
		mixed_order();
		hold_results();
		$display("errors: %0d mismatch, %0d timeout, %0d other",
			mismatch_errs, timeout_errs, other_errs);
		if (mismatch_errs + timeout_errs + other_errs == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end
endmodule

`default_nettype wire

//--- exec_unit.f
+incdir+dv
hw/exec_pkg.sv
hw/exec_if.sv
hw/exec_issue.sv
hw/alu_path.sv
hw/div_path.sv
hw/hilo_writeback.sv
hw/exec_unit.sv
dv/exec_unit_tb.sv
